//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f vlog.f --top-module tb_gb_cart -o sim_tb_gb_cart
./obj_dir/sim_tb_gb_cart

//--- verification/gb_cart_asserts.sv
module gb_cart_asserts (
	input logic clk_sys,
	input logic reset,
	input logic sd_rd,
	input logic sd_wr,
	input logic sd_ack,
	input logic bk_busy
);

	timeunit 1ns;
	timeprecision 1ps;

	// --------------------
	// request levels
	// --------------------
	// one direction at a time
	a_req_onehot: assert property (@(posedge clk_sys) disable iff (reset)
		!(sd_rd && sd_wr))
		else $error("sd_rd and sd_wr are high in the same cycle");

	// a new request is only raised while the host is not acking
	a_req_no_ack: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(sd_rd || sd_wr) |-> !$past(sd_ack))
		else $error("sd request raised while sd_ack was high");

	// idle out of reset
	a_idle_reset: assert property (@(posedge clk_sys)
		reset |=> !bk_busy)
		else $error("bk_busy high right after reset");

endmodule

//--- verification/tb_gb_cart.sv
module tb_gb_cart import cart_pkg::*, backup_pkg::*; ();

	timeunit 1ns;
	timeprecision 1ps;

	localparam int N_HDR   = 20;  // header only downloads
	localparam int N_CART  = 6;   // carts for the mixed cpu test
	localparam int N_OPS   = 160; // cpu ops per cart
	localparam int N_SAVEW = 60;  // cpu writes before the save
	localparam int TIMEOUT_CYCLES = 2 * 256 * (SECTOR_WORDS + 4) + N_HDR * 8
		+ N_CART * (N_OPS * 2 + 8) + N_SAVEW * 2 + 2000;

	logic                   clk_sys;
	logic                   reset;
	dl_bus_t                dl;
	cpu_bus_t               cpu;
	logic                   cpu_ce;
	logic                   img_mounted;
	logic                   img_readonly;
	logic                   img_nonzero;
	logic                   bk_load;
	logic                   bk_save;
	sd_buf_t                sd_buf;
	sd_req_t                sd_req;
	logic [15:0]            sd_buff_din;
	logic [ROM_WADDR_W-1:0] rom_word_addr;
	logic [7:0]             ram_rdata;
	logic                   sav_pending;
	logic                   bk_busy;
	cart_hdr_t              hdr;

	// reference model state
	logic [7:0] ram_img [2**CRAM_ADDR_W]; // byte image of cart ram
	cart_hdr_t  m_hdr;
	logic [8:0] m_rom_bank;
	logic [3:0] m_ram_bank;
	logic       m_mode;
	logic       m_rtc;
	logic       m_en;
	logic [31:0] lfsr;
	int         cycles;

	gb_cart_top u_dut (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl            (dl),
		.cpu           (cpu),
		.cpu_ce        (cpu_ce),
		.img_mounted   (img_mounted),
		.img_readonly  (img_readonly),
		.img_nonzero   (img_nonzero),
		.bk_load       (bk_load),
		.bk_save       (bk_save),
		.sd_buf        (sd_buf),
		.sd_req        (sd_req),
		.sd_buff_din   (sd_buff_din),
		.rom_word_addr (rom_word_addr),
		.ram_rdata     (ram_rdata),
		.sav_pending   (sav_pending),
		.bk_busy       (bk_busy),
		.hdr           (hdr)
	);

	bind backup_fsm gb_cart_asserts u_asserts (
		.clk_sys (clk_sys),
		.reset   (reset),
		.sd_rd   (sd_rd),
		.sd_wr   (sd_wr),
		.sd_ack  (sd_ack),
		.bk_busy (bk_busy)
	);

	initial begin
		clk_sys = 1'b0;
		forever #2 clk_sys = ~clk_sys; // 4 ns
	end

	// --------------------
	// failure and timeout
	// --------------------
	task automatic stop_with_error(input string msg);
		$display("%s", msg);
		$display("RESULT: FAIL");
		$fatal(1);
	endtask

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES)
			stop_with_error("timeout, the run did not finish within the cycle limit");
	end

	// --------------------
	// random numbers
	// --------------------
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]}; // taps 32 22 2 1
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_next(lfsr); // one step per bit
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	// --------------------
	// compare tasks
	// --------------------
	task automatic check_rom_addr(input logic [ROM_WADDR_W-1:0] got, exp);
		if (got !== exp)
			stop_with_error($sformatf("error rom_word_addr got %h exp %h", got, exp));
	endtask

	task automatic check_ram_byte(input logic [7:0] got, exp);
		if (got !== exp)
			stop_with_error($sformatf("error ram_rdata got %h exp %h", got, exp));
	endtask

	task automatic check_sd_word(input logic [15:0] got, exp);
		if (got !== exp)
			stop_with_error($sformatf("error sd_buff_din got %h exp %h", got, exp));
	endtask

	task automatic check_hdr(input cart_hdr_t got, exp);
		if (got !== exp)
			stop_with_error($sformatf("error hdr got %h exp %h", got, exp));
	endtask

	task automatic check_lba(input string name, input logic [LBA_W-1:0] got, exp);
		if (got !== exp)
			stop_with_error($sformatf("error %s got %h exp %h", name, got, exp));
	endtask

	task automatic check_bit(input string name, input logic got, exp);
		if (got !== exp)
			stop_with_error($sformatf("error %s got %h exp %h", name, got, exp));
	endtask

	// --------------------
	// reference model
	// --------------------
	function automatic cart_hdr_t expected_header(input logic [7:0] mt, rs, rms);
		cart_hdr_t h;
		h = '0;
		h.mbc_type = mt;
		h.rom_size = rs;
		h.ram_size = rms;
		if (mt >= 8'h01 && mt <= 8'h03)      h.kind = kind_mbc1;
		else if (mt >= 8'h05 && mt <= 8'h06) h.kind = kind_mbc2;
		else if (mt >= 8'h0F && mt <= 8'h13) h.kind = kind_mbc3;
		else if (mt >= 8'h19 && mt <= 8'h1E) h.kind = kind_mbc5;
		else                                 h.kind = kind_none;
		h.battery  = mt inside {8'h03, 8'h06, 8'h09, 8'h0D, 8'h10,
			8'h13, 8'h1B, 8'h1E, 8'h22, 8'hFF};
		h.rom_mask = (rs <= 8'h08) ? 9'((2 << rs) - 1) : 9'h07F; // odd sizes at 128
		if (rms == 8'h03)     h.ram_mask = 4'h3;
		else if (rms <= 8'h02) h.ram_mask = 4'h0;
		else                  h.ram_mask = 4'hF;
		return h;
	endfunction

	function automatic logic [1:0] mbc1_hi(input logic [15:0] a);
		return m_ram_bank[1:0] & {2{a[14] | m_mode}};
	endfunction

	function automatic logic [ROM_WADDR_W-1:0] model_rom_addr(input logic [15:0] a);
		logic [8:0] rb;
		logic [8:0] b;
		rb = a[14] ? m_rom_bank : 9'd0; // lower 16k is bank 0
		case (m_hdr.kind)
			kind_mbc1: b = {2'b00, mbc1_hi(a), rb[4:0]} & m_hdr.rom_mask;
			kind_mbc2, kind_mbc3: b = {2'b00, rb[6:0]} & m_hdr.rom_mask;
			kind_mbc5: b = rb & m_hdr.rom_mask;
			default: b = {8'd0, a[14]};
		endcase
		return {b, a[13:1]};
	endfunction

	function automatic logic [CRAM_ADDR_W-1:0] model_ram_addr(input logic [15:0] a);
		logic [3:0] rbk;
		case (m_hdr.kind)
			kind_mbc1: rbk = {2'b00, mbc1_hi(a) & m_hdr.ram_mask[1:0]};
			kind_mbc3: rbk = {2'b00, m_ram_bank[1:0] & m_hdr.ram_mask[1:0]};
			kind_mbc5: rbk = m_ram_bank & m_hdr.ram_mask;
			default:   rbk = 4'd0;
		endcase
		return {rbk, a[12:0]};
	endfunction

	function automatic logic [7:0] model_read(input logic [15:0] a);
		logic [7:0] b;
		b = ram_img[model_ram_addr(a)];
		if (!m_en) return 8'hFF;
		if (m_rtc) return 8'h00;
		if (m_hdr.kind == kind_mbc2) return {4'hF, b[3:0]};
		return b;
	endfunction

	task automatic model_cpu_write(input logic [15:0] a, input logic [7:0] d);
		if (a[15:13] == 3'b101)
			ram_img[model_ram_addr(a)] = d; // lands even while disabled
		if (!a[15]) begin
			case (a[14:13])
				2'b00: m_en = (d[3:0] == RAM_ENABLE_KEY);
				2'b01: begin
					if (m_hdr.kind == kind_mbc5) begin
						if (a[12]) m_rom_bank[8] = d[0];
						else       m_rom_bank[7:0] = d;
					end else if (d[6:0] == 7'd0)
						m_rom_bank = 9'd1;
					else
						m_rom_bank = {2'b00, d[6:0]};
				end
				2'b10: begin
					if (m_hdr.kind == kind_mbc3 && d[3])
						m_rtc = 1'b1;
					else if (m_hdr.kind == kind_mbc5)
						m_ram_bank = d[3:0];
					else begin
						m_rtc      = 1'b0;
						m_ram_bank = {2'b00, d[1:0]};
					end
				end
				default: if (m_hdr.kind == kind_mbc1) m_mode = d[0];
			endcase
		end
	endtask

	// --------------------
	// bus drivers enter and leave on a falling edge
	// --------------------
	task automatic cpu_write(input logic [15:0] a, input logic [7:0] d);
		cpu.addr  = a;
		cpu.wdata = d;
		cpu.wr    = 1'b1;
		cpu_ce    = 1'b1;
		model_cpu_write(a, d);
		@(negedge clk_sys);
		cpu.wr = 1'b0;
		cpu_ce = 1'b0;
	endtask

	task automatic rom_read(input logic [15:0] a);
		cpu.addr = a;
		cpu.rd   = 1'b1;
		#1;                          // combinational path settles
		check_rom_addr(rom_word_addr, model_rom_addr(a));
		@(negedge clk_sys);
		cpu.rd = 1'b0;
	endtask

	task automatic ram_read(input logic [15:0] a);
		logic [7:0] exp;
		exp      = model_read(a);
		cpu.addr = a;
		cpu.rd   = 1'b1;
		@(negedge clk_sys);          // one cycle read latency
		check_ram_byte(ram_rdata, exp);
		cpu.rd = 1'b0;
	endtask

	task automatic download_header(input logic [7:0] mt, rs, rms, input logic mount, nonzero);
		dl.active   = 1'b1;
		img_nonzero = nonzero;
		@(negedge clk_sys);
		dl.wr       = 1'b1;
		dl.addr     = HDR_TYPE_ADDR;
		dl.data     = {mt, 8'h00};
		img_mounted = mount;
		@(negedge clk_sys);
		dl.addr     = HDR_SIZE_ADDR;
		dl.data     = {rms, rs};
		img_mounted = 1'b0;
		@(negedge clk_sys);
		dl.wr = 1'b0;
		@(negedge clk_sys);
		dl.active = 1'b0;
		m_hdr      = expected_header(mt, rs, rms);
		m_rom_bank = 9'd1; // mapper regs cleared by the download
		m_ram_bank = 4'd0;
		m_mode     = 1'b0;
		m_rtc      = 1'b0;
		m_en       = 1'b0;
		@(negedge clk_sys);
		check_hdr(hdr, m_hdr);
	endtask

	// sd host serves sectors until bk_busy drops
	task automatic sd_host(input logic load, input int exp_sectors);
		int         n;
		logic       done;
		logic [7:0] sec;
		n    = 0;
		done = 1'b0;
		while (!done) begin
			while (!(sd_req.rd || sd_req.wr))
				@(negedge clk_sys);
			check_bit("sd_req.rd", sd_req.rd, load);
			check_lba("sd_req.lba", sd_req.lba, n);
			sec        = sd_req.lba[7:0];
			sd_buf.ack = 1'b1;
			@(negedge clk_sys);
			for (int i = 0; i < SECTOR_WORDS; i++) begin
				sd_buf.addr = 8'(i);
				if (load) begin
					sd_buf.dout = 16'(rand_bits(16));
					sd_buf.wr   = 1'b1;
					ram_img[{sec, 8'(i), 1'b0}] = sd_buf.dout[7:0];
					ram_img[{sec, 8'(i), 1'b1}] = sd_buf.dout[15:8];
					@(negedge clk_sys);
				end else begin
					@(negedge clk_sys); // buffer read latency
					check_sd_word(sd_buff_din,
						{ram_img[{sec, 8'(i), 1'b1}], ram_img[{sec, 8'(i), 1'b0}]});
				end
			end
			sd_buf.wr  = 1'b0;
			sd_buf.ack = 1'b0;
			@(negedge clk_sys);
			n++;
			if (!bk_busy)
				done = 1'b1;
		end
		check_lba("sector count", n, exp_sectors);
		check_bit("sav_pending", sav_pending, 1'b0);
	endtask

	// mixed bank, enable and ram traffic on the current cart
	task automatic cpu_mix(input int ops);
		logic [2:0]  op;
		logic [15:0] off;
		for (int k = 0; k < ops; k++) begin
			op  = 3'(rand_bits(3));
			off = 16'(rand_bits(13));
			case (op)
				3'd0: cpu_write(16'h2000 | off,
					(rand_bits(2) == 0) ? 8'h00 : 8'(rand_bits(8))); // rom bank incl 0x3000
				3'd1: cpu_write(16'h4000 | off, 8'(rand_bits(8)));  // ram bank or rtc select
				3'd2: cpu_write(16'h6000 | off, 8'(rand_bits(8)));  // mbc1 mode
				3'd3: cpu_write(off, rand_bits(1) ? 8'h0A : 8'(rand_bits(8)));
				3'd6: cpu_write(16'hA000 | off, 8'(rand_bits(8)));
				3'd7: ram_read(16'hA000 | off);
				default: rom_read(16'(rand_bits(15)));
			endcase
		end
	endtask

	// --------------------
	// test sequence
	// --------------------
	initial begin
		logic [7:0] codes [20];
		logic [7:0] carts [N_CART][3];
		codes = '{8'h00, 8'h01, 8'h02, 8'h03, 8'h05, 8'h06, 8'h0F, 8'h10, 8'h11, 8'h12,
			8'h13, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1E, 8'h22, 8'hFF, 8'h08, 8'h0D};
		carts = '{'{8'h03, 8'h05, 8'h03}, '{8'h06, 8'h01, 8'h00}, '{8'h13, 8'h05, 8'h03},
			'{8'h1B, 8'h08, 8'h04}, '{8'h00, 8'h00, 8'h00}, '{8'h11, 8'h07, 8'h02}};
		lfsr         = 32'd32711;
		cycles       = 0;
		reset        = 1'b1;
		dl           = '0;
		cpu          = '0;
		cpu_ce       = 1'b0;
		img_mounted  = 1'b0;
		img_readonly = 1'b0;
		img_nonzero  = 1'b0;
		bk_load      = 1'b0;
		bk_save      = 1'b0;
		sd_buf       = '0;
		repeat (4) @(posedge clk_sys);
		@(negedge clk_sys);
		reset = 1'b0;
		check_bit("bk_busy", bk_busy, 1'b0);
		check_bit("sd_req.rd", sd_req.rd, 1'b0);
		check_bit("sd_req.wr", sd_req.wr, 1'b0);
		check_bit("sav_pending", sav_pending, 1'b0);

		// header decode over random codes
		for (int i = 0; i < N_HDR; i++)
			download_header(codes[5'(rand_bits(5)) % 20], 8'(rand_bits(4)),
				8'(rand_bits(3)), 1'b0, 1'b0);

		// autoload fills the whole 128k from the host
		download_header(8'h1B, 8'h06, 8'h04, 1'b1, 1'b1);
		check_bit("bk_busy", bk_busy, 1'b1);
		sd_host(1'b1, 256);
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < 40; i++) begin
			cpu_write(16'h4000, 8'(rand_bits(4)));
			ram_read(16'hA000 | 16'(rand_bits(13)));
		end

		// banking and ram access per mapper
		for (int c = 0; c < N_CART; c++) begin
			download_header(carts[c][0], carts[c][1], carts[c][2], 1'b0, 1'b0);
			cpu_mix(N_OPS);
		end

		// save after dirty writes
		download_header(8'h1B, 8'h08, 8'h04, 1'b1, 1'b0);
		cpu_write(16'h0000, 8'h0A);
		for (int i = 0; i < N_SAVEW / 2; i++) begin
			cpu_write(16'h4000, 8'(rand_bits(4)));
			cpu_write(16'hA000 | 16'(rand_bits(13)), 8'(rand_bits(8)));
		end
		check_bit("sav_pending", sav_pending, 1'b1);
		bk_save = 1'b1;
		sd_host(1'b0, 256);
		bk_save = 1'b0;

		$display("RESULT: PASS");
		$finish;
	end

endmodule

//--- verilog/backup_fsm.sv
module backup_fsm import cart_pkg::*; (
	input  logic      clk_sys,
	input  logic      reset,
	input  logic      dl_active,
	input  logic      img_mounted,
	input  logic      img_readonly,
	input  logic      img_nonzero,
	input  logic      bk_load,
	input  logic      bk_save,
	input  cart_hdr_t hdr,
	input  logic      ram_write,
	input  logic      sd_ack,
	input  logic      last,
	output logic      start,
	output logic      step,
	output logic      sd_rd,
	output logic      sd_wr,
	output logic      bk_busy,
	output logic      sav_pending
);

	typedef enum logic [1:0] {st_idle, st_request, st_wait_done} state_t;

	state_t state;
	logic   old_load, old_save, old_ack, old_dl;
	logic   bk_ena;     // writable save image mounted for this cart
	logic   loading;
	logic   supported;
	logic   load_edge, user_req, auto_load;
	logic   ack_rise, ack_fall;
	logic   new_loading;

	// --------------------
	// edges and status
	// --------------------
	assign load_edge = bk_load & ~old_load;
	assign user_req  = bk_ena & (load_edge | (bk_save & ~old_save));
	assign auto_load = old_dl & ~dl_active & img_nonzero & bk_ena; // end of download
	assign ack_rise  = sd_ack & ~old_ack;
	assign ack_fall  = ~sd_ack & old_ack;
	assign supported = bk_ena & hdr.battery & ((|hdr.ram_size) | (hdr.kind == kind_mbc2));

	assign new_loading = auto_load | load_edge;
	assign start       = (state == st_idle) & (user_req | auto_load);
	assign step        = (state == st_wait_done) & ack_fall & ~last;
	assign bk_busy     = (state != st_idle);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			old_load    <= 1'b0;
			old_save    <= 1'b0;
			old_ack     <= 1'b0;
			old_dl      <= 1'b0;
			bk_ena      <= 1'b0;
			loading     <= 1'b0;
			sav_pending <= 1'b0;
			sd_rd       <= 1'b0;
			sd_wr       <= 1'b0;
			state       <= st_idle;
		end else begin
			old_load <= bk_load;
			old_save <= bk_save;
			old_ack  <= sd_ack;
			old_dl   <= dl_active;

			if (!old_dl && dl_active)
				bk_ena <= 1'b0;  // new cart, forget the old image
			if (dl_active && img_mounted && !img_readonly)
				bk_ena <= 1'b1;

			if (start)
				sav_pending <= 1'b0;
			else if (ram_write && supported)
				sav_pending <= 1'b1; // unsaved cpu write

			case (state)
				st_idle: begin
					if (start) begin
						loading <= new_loading;
						sd_rd   <= new_loading;
						sd_wr   <= ~new_loading;
						state   <= st_request;
					end
				end
				st_request: begin
					if (ack_rise) begin // host took the request
						sd_rd <= 1'b0;
						sd_wr <= 1'b0;
						state <= st_wait_done;
					end
				end
				default: begin
					if (ack_fall) begin
						if (last)
							state <= st_idle;
						else begin
							sd_rd <= loading;  // next lba, counter steps now
							sd_wr <= ~loading;
							state <= st_request;
						end
					end
				end
			endcase
		end
	end

endmodule

//--- verilog/backup_pkg.sv
package backup_pkg;

	// --------------------
	// sector geometry
	// --------------------
	localparam int SECTOR_WORDS = 256;                  // 512 bytes as 16 bit words
	localparam int SECTOR_AW    = $clog2(SECTOR_WORDS); // buffer word address
	localparam int LBA_W        = 32;

	// request side, levels held until ack rises
	typedef struct packed {
		logic             rd;  // load, sd to ram
		logic             wr;  // save, ram to sd
		logic [LBA_W-1:0] lba;
	} sd_req_t;

	// buffer side, driven by the sd host
	typedef struct packed {
		logic                 ack;  // high for the whole sector
		logic [SECTOR_AW-1:0] addr;
		logic                 wr;   // load data strobe
		logic [15:0]          dout;
	} sd_buf_t;

endpackage

//--- verilog/cart_header.sv
module cart_header import cart_pkg::*; (
	input  logic      clk_sys,
	input  dl_bus_t   dl,
	output cart_hdr_t hdr
);

	logic [7:0] mbc_type;
	logic [7:0] rom_size;
	logic [7:0] ram_size;

	// grab header words as they stream past
	always_ff @(posedge clk_sys) begin
		if (dl.active && dl.wr) begin
			case (dl.addr)
				HDR_TYPE_ADDR: mbc_type <= dl.data[15:8]; // low byte is sgb flag
				HDR_SIZE_ADDR: {ram_size, rom_size} <= dl.data;
				default: ;
			endcase
		end
	end

	always_comb begin
		hdr = '0;
		hdr.mbc_type = mbc_type;
		hdr.rom_size = rom_size;
		hdr.ram_size = ram_size;

		// mapper from code ranges
		if (mbc_type inside {[8'h01:8'h03]})
			hdr.kind = kind_mbc1;
		else if (mbc_type inside {[8'h05:8'h06]})
			hdr.kind = kind_mbc2;
		else if (mbc_type inside {[8'h0F:8'h13]})
			hdr.kind = kind_mbc3;
		else if (mbc_type inside {[8'h19:8'h1E]})
			hdr.kind = kind_mbc5;
		else
			hdr.kind = kind_none; // plain rom, 32k linear

		for (int i = 0; i < BATTERY_N; i++) begin
			if (mbc_type == BATTERY_TYPES[i])
				hdr.battery = 1'b1;
		end

		case (rom_size)
			8'h00:   hdr.rom_mask = 9'h001; // 2 banks
			8'h01:   hdr.rom_mask = 9'h003;
			8'h02:   hdr.rom_mask = 9'h007;
			8'h03:   hdr.rom_mask = 9'h00F;
			8'h04:   hdr.rom_mask = 9'h01F;
			8'h05:   hdr.rom_mask = 9'h03F;
			8'h06:   hdr.rom_mask = 9'h07F; // 128 banks, 2 MB
			8'h07:   hdr.rom_mask = 9'h0FF;
			8'h08:   hdr.rom_mask = 9'h1FF; // 512 banks, 8 MB
			default: hdr.rom_mask = 9'h07F; // 72/80/96 bank carts mirror at 128
		endcase

		case (ram_size)
			8'h03:   hdr.ram_mask = 4'h3; // 32k, 4 banks
			8'h00, 8'h01, 8'h02: hdr.ram_mask = 4'h0; // one bank or less
			default: hdr.ram_mask = 4'hF; // 128k, 16 banks
		endcase
	end

endmodule

//--- verilog/cart_pkg.sv
package cart_pkg;

	// --------------------
	// header locations, keys, widths
	// --------------------
	localparam logic [24:0] HDR_TYPE_ADDR  = 25'h146; // mapper code in high byte
	localparam logic [24:0] HDR_SIZE_ADDR  = 25'h148; // {ram size, rom size}
	localparam logic [3:0]  RAM_ENABLE_KEY = 4'hA;    // low nibble unlocks cart ram

	localparam int ROM_WADDR_W = 22; // 512 banks x 8K words
	localparam int CRAM_ADDR_W = 17; // 16 banks x 8 KB

	// mapper codes that come with a battery
	localparam int BATTERY_N = 10;
	localparam logic [BATTERY_N-1:0][7:0] BATTERY_TYPES = {
		8'h03, 8'h06, 8'h09, 8'h0D, 8'h10,
		8'h13, 8'h1B, 8'h1E, 8'h22, 8'hFF
	};

	// --------------------
	// mapper kind and header
	// --------------------
	typedef enum logic [2:0] {
		kind_none,
		kind_mbc1,
		kind_mbc2,
		kind_mbc3,
		kind_mbc5
	} mbc_kind_t;

	typedef struct packed {
		logic [7:0] mbc_type;  // raw 0x147
		logic [7:0] rom_size;  // raw 0x148
		logic [7:0] ram_size;  // raw 0x149
		mbc_kind_t  kind;
		logic [8:0] rom_mask;  // bank mirroring
		logic [3:0] ram_mask;
		logic       battery;
	} cart_hdr_t;

	// --------------------
	// buses
	// --------------------
	typedef struct packed {
		logic        active; // rom image download running
		logic        wr;
		logic [24:0] addr;   // byte address, even
		logic [15:0] data;
	} dl_bus_t;

	typedef struct packed {
		logic [15:0] addr;
		logic        rd;
		logic        wr;
		logic [7:0]  wdata;
	} cpu_bus_t;

	// cpu write byte, two decodes of the same bits
	typedef struct packed {
		logic       msb;  // only mbc5 keeps it
		logic [6:0] low;  // mbc1-3 bank number
	} rom_bank_view_t;

	typedef struct packed {
		logic [3:0] pad;
		logic [3:0] bank; // bit 3 doubles as mbc3 rtc select
	} ram_ctl_view_t;

	typedef union packed {
		rom_bank_view_t rom;
		ram_ctl_view_t  ram;
	} mbc_wdata_u;

endpackage

//--- verilog/cart_ram.sv
module cart_ram import cart_pkg::*, backup_pkg::*; (
	input  logic                   clk_sys,
	input  logic [CRAM_ADDR_W-1:0] cram_addr,
	input  logic                   cram_sel,
	input  cpu_bus_t               cpu,
	input  logic                   ram_enabled,
	input  logic                   rtc_sel,
	input  logic                   is_mbc2,
	input  logic [7:0]             lba_low,   // sector number within the save
	input  sd_buf_t                sd_buf,
	output logic [15:0]            sd_buff_din,
	output logic [7:0]             ram_rdata,
	output logic                   ram_write
);

	localparam int WORDS = 2 ** (CRAM_ADDR_W - 1); // 64K words, 128 KB

	logic [CRAM_ADDR_W-2:0] bk_addr;
	logic                   bk_wr;
	logic [1:0][7:0]        cpu_q;  // per lane
	logic [1:0][7:0]        sd_q;
	logic [7:0]             q;
	logic                   sel_hi; // lane of the last cpu access
	logic                   en_q;
	logic                   rtc_q;
	logic                   mbc2_q;

	assign ram_write = cpu.wr & cram_sel;
	assign bk_addr   = {lba_low, sd_buf.addr};
	assign bk_wr     = sd_buf.wr & sd_buf.ack; // load writes whole words

	// --------------------
	// two byte lanes, word addressed
	// --------------------
	for (genvar l = 0; l < 2; l++) begin : g_lane
		logic [7:0] mem [WORDS];

		always_ff @(posedge clk_sys) begin
			if (ram_write && cram_addr[0] == 1'(l))
				mem[cram_addr[CRAM_ADDR_W-1:1]] <= cpu.wdata;
			cpu_q[l] <= mem[cram_addr[CRAM_ADDR_W-1:1]];

			if (bk_wr)
				mem[bk_addr] <= sd_buf.dout[l*8 +: 8];
			sd_q[l] <= mem[bk_addr];
		end
	end

	// flags follow the data by one cycle
	always_ff @(posedge clk_sys) begin
		sel_hi <= cram_addr[0];
		en_q   <= ram_enabled;
		rtc_q  <= rtc_sel;
		mbc2_q <= is_mbc2;
	end

	assign sd_buff_din = sd_q; // high lane on [15:8]
	assign q           = sel_hi ? cpu_q[1] : cpu_q[0];

	always_comb begin
		if (!en_q)
			ram_rdata = 8'hFF;           // disabled, open bus
		else if (rtc_q)
			ram_rdata = 8'h00;           // rtc not modelled
		else if (mbc2_q)
			ram_rdata = {4'hF, q[3:0]};  // 4 bit cells
		else
			ram_rdata = q;
	end

endmodule

//--- verilog/gb_cart_top.sv
module gb_cart_top import cart_pkg::*, backup_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  dl_bus_t                dl,
	input  cpu_bus_t               cpu,
	input  logic                   cpu_ce,
	input  logic                   img_mounted,
	input  logic                   img_readonly,
	input  logic                   img_nonzero,
	input  logic                   bk_load,
	input  logic                   bk_save,
	input  sd_buf_t                sd_buf,
	output sd_req_t                sd_req,
	output logic [15:0]            sd_buff_din,
	output logic [ROM_WADDR_W-1:0] rom_word_addr,
	output logic [7:0]             ram_rdata,
	output logic                   sav_pending,
	output logic                   bk_busy,
	output cart_hdr_t              hdr
);

	logic [CRAM_ADDR_W-1:0] cram_addr;
	logic                   cram_sel;
	logic                   ram_enabled;
	logic                   rtc_sel;
	logic                   ram_write;
	logic                   seq_start;
	logic                   seq_step;
	logic                   last_sector;
	logic                   is_mbc2;

	assign is_mbc2 = (hdr.kind == kind_mbc2);

	cart_header u_header (
		.clk_sys (clk_sys),
		.dl      (dl),
		.hdr     (hdr)
	);

	// --------------------
	// cpu side
	// --------------------
	mbc_regs u_mbc (
		.clk_sys       (clk_sys),
		.reset         (reset),
		.dl_active     (dl.active),
		.cpu           (cpu),
		.cpu_ce        (cpu_ce),
		.hdr           (hdr),
		.rom_word_addr (rom_word_addr),
		.cram_addr     (cram_addr),
		.cram_sel      (cram_sel),
		.ram_enabled   (ram_enabled),
		.rtc_sel       (rtc_sel)
	);

	cart_ram u_ram (
		.clk_sys     (clk_sys),
		.cram_addr   (cram_addr),
		.cram_sel    (cram_sel),
		.cpu         (cpu),
		.ram_enabled (ram_enabled),
		.rtc_sel     (rtc_sel),
		.is_mbc2     (is_mbc2),
		.lba_low     (sd_req.lba[7:0]),
		.sd_buf      (sd_buf),
		.sd_buff_din (sd_buff_din),
		.ram_rdata   (ram_rdata),
		.ram_write   (ram_write)
	);

	// --------------------
	// backup transfer
	// --------------------
	backup_fsm u_seq (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.dl_active    (dl.active),
		.img_mounted  (img_mounted),
		.img_readonly (img_readonly),
		.img_nonzero  (img_nonzero),
		.bk_load      (bk_load),
		.bk_save      (bk_save),
		.hdr          (hdr),
		.ram_write    (ram_write),
		.sd_ack       (sd_buf.ack),
		.last         (last_sector),
		.start        (seq_start),
		.step         (seq_step),
		.sd_rd        (sd_req.rd),
		.sd_wr        (sd_req.wr),
		.bk_busy      (bk_busy),
		.sav_pending  (sav_pending)
	);

	sector_counter u_sector (
		.clk_sys  (clk_sys),
		.reset    (reset),
		.start    (seq_start),
		.step     (seq_step),
		.ram_size (hdr.ram_size),
		.is_mbc2  (is_mbc2),
		.lba      (sd_req.lba),
		.last     (last_sector)
	);

endmodule

//--- verilog/mbc_regs.sv
module mbc_regs import cart_pkg::*; (
	input  logic                   clk_sys,
	input  logic                   reset,
	input  logic                   dl_active,
	input  cpu_bus_t               cpu,
	input  logic                   cpu_ce,
	input  cart_hdr_t              hdr,
	output logic [ROM_WADDR_W-1:0] rom_word_addr,
	output logic [CRAM_ADDR_W-1:0] cram_addr,
	output logic                   cram_sel,
	output logic                   ram_enabled,
	output logic                   rtc_sel
);

	mbc_wdata_u wd;
	logic [8:0] rom_bank_reg;
	logic [3:0] ram_bank_reg; // 0-15
	logic       mbc1_mode;    // 1 = bank2 passthrough
	logic       rtc_mode;
	logic       ram_enable;
	logic       reg_wr;
	logic [8:0] rom_bank;     // after bank 0 forcing
	logic [8:0] bank;         // final, masked
	logic [1:0] mbc1_bank2;
	logic [3:0] ram_bank;

	assign wd     = cpu.wdata;
	assign reg_wr = cpu_ce & cpu.wr & ~cpu.addr[15]; // 0x0000-0x7fff

	// --------------------
	// register writes
	// --------------------
	always_ff @(posedge clk_sys) begin
		if (reset || dl_active) begin
			rom_bank_reg <= 9'd1;
			ram_bank_reg <= 4'd0;
			mbc1_mode    <= 1'b0;
			rtc_mode     <= 1'b0;
			ram_enable   <= 1'b0;
		end else if (reg_wr) begin
			case (cpu.addr[14:13])
				2'b00: ram_enable <= (wd.ram.bank == RAM_ENABLE_KEY);
				2'b01: begin
					if (hdr.kind == kind_mbc5) begin
						if (cpu.addr[12])
							rom_bank_reg[8] <= wd.rom.low[0]; // 0x3000 high bit
						else
							rom_bank_reg[7:0] <= wd.rom;      // full byte, 0 allowed
					end else if (wd.rom.low == 7'd0)
						rom_bank_reg <= 9'd1;                 // bank 0 reads as 1
					else
						rom_bank_reg <= {2'b00, wd.rom.low};
				end
				2'b10: begin
					if (hdr.kind == kind_mbc3 && wd.ram.bank[3])
						rtc_mode <= 1'b1; // rtc regs, read as zero here
					else if (hdr.kind == kind_mbc5)
						ram_bank_reg <= wd.ram.bank;
					else begin
						rtc_mode     <= 1'b0;
						ram_bank_reg <= {2'b00, wd.ram.bank[1:0]};
					end
				end
				default: begin
					if (hdr.kind == kind_mbc1)
						mbc1_mode <= wd.rom.low[0];
				end
			endcase
		end
	end

	// --------------------
	// address translation
	// --------------------
	// mode 0 ands bank2 with a14, mode 1 passes it everywhere
	assign mbc1_bank2 = ram_bank_reg[1:0] & {2{cpu.addr[14] | mbc1_mode}};
	assign rom_bank   = cpu.addr[14] ? rom_bank_reg : 9'd0; // 0x0000-0x3fff

	always_comb begin
		case (hdr.kind)
			kind_mbc1: begin
				bank     = {2'b00, mbc1_bank2, rom_bank[4:0]} & hdr.rom_mask;
				ram_bank = {2'b00, mbc1_bank2 & hdr.ram_mask[1:0]};
			end
			kind_mbc2: begin
				bank     = {2'b00, rom_bank[6:0]} & hdr.rom_mask; // 16 banks at most
				ram_bank = 4'd0;                                  // 512 x 4 internal
			end
			kind_mbc3: begin
				bank     = {2'b00, rom_bank[6:0]} & hdr.rom_mask;
				ram_bank = {2'b00, ram_bank_reg[1:0] & hdr.ram_mask[1:0]};
			end
			kind_mbc5: begin
				bank     = rom_bank & hdr.rom_mask;
				ram_bank = ram_bank_reg & hdr.ram_mask;
			end
			default: begin
				bank     = {8'd0, cpu.addr[14]}; // no mapper
				ram_bank = 4'd0;
			end
		endcase
	end

	assign rom_word_addr = {bank, cpu.addr[13:1]};     // 8K words per bank
	assign cram_addr     = {ram_bank, cpu.addr[12:0]};
	assign cram_sel      = (cpu.addr[15:13] == 3'b101); // 0xa000-0xbfff
	assign ram_enabled   = ram_enable;
	assign rtc_sel       = rtc_mode;

endmodule

//--- verilog/sector_counter.sv
module sector_counter import backup_pkg::*; (
	input  logic             clk_sys,
	input  logic             reset,
	input  logic             start,
	input  logic             step,
	input  logic [7:0]       ram_size,
	input  logic             is_mbc2,
	output logic [LBA_W-1:0] lba,
	output logic             last
);

	logic [7:0] limit; // index of the final sector

	always_comb begin
		if (is_mbc2)
			limit = 8'd1;            // 512 cells, 1 KB file
		else begin
			case (ram_size)
				8'h01:   limit = 8'd3;   // 2 KB
				8'h02:   limit = 8'd15;  // 8 KB
				8'h03:   limit = 8'd63;  // 32 KB
				default: limit = 8'd255; // 128 KB
			endcase
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset || start)
			lba <= '0;
		else if (step)
			lba <= lba + 1'b1; // next sector
	end

	assign last = (lba[7:0] >= limit);

endmodule

//--- vlog.f
verilog/cart_pkg.sv
verilog/backup_pkg.sv
verilog/cart_header.sv
verilog/mbc_regs.sv
verilog/cart_ram.sv
verilog/sector_counter.sv
verilog/backup_fsm.sv
verilog/gb_cart_top.sv
verification/gb_cart_asserts.sv
verification/tb_gb_cart.sv
